/* rtl/event_ctrl.sv */
`timescale 1ns/1ps

module event_ctrl import phold_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   evt_ctx_if.source         ctx,
   input  logic              event_valid,
   input  event_msg_t        event_msg,
   input  sim_time_t         global_time,
   input  logic [NB_RND-1:0] random_in,
   input  logic              stall,
   input  logic              ack,
   output logic              ready,
   output logic              active,
   input  logic              rd_done,
   input  logic              wr_done,
   output hist_entry_t       gen_entry,
   output logic              gen_push,
   input  logic              discard_cur,
   input  logic              gen_cancel,
   input  event_msg_t        cancel_msg,
   input  logic              rbk_empty,
   input  hist_entry_t       rbk_head,
   output logic              rbk_pop,
   input  hist_cnt_t         hist_count,
   output hist_cnt_t         new_hist_size,
   output logic              new_event_ready,
   output event_msg_t        out_event_msg,
   output core_state_e       state
);

   core_state_e       state_next;
   lp_id_t            cur_lp;
   sim_time_t         cur_time;
   evt_type_e         cur_type;
   sim_time_t         gvt;
   logic [NB_RND-1:0] rnd;
   logic [3:0]        delay_cnt;
   logic              accept;
   logic              ack_wait;
   logic              pair_half;    // Cancel of the head pair already sent
   sim_time_t         new_time;
   sim_time_t         new_offset;
   lp_id_t            new_target;
   event_msg_t        primary_msg;

   assign ready    = (state == IDLE);
   assign active   = (state != IDLE);
   assign accept   = ready && event_valid;
   assign ack_wait = (state == WAIT) && ack;

   assign ctx.cur_lp   = cur_lp;
   assign ctx.cur_time = cur_time;
   assign ctx.cur_type = cur_type;
   assign ctx.gvt      = gvt;
   assign ctx.in_idle  = ready;

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_lp   <= event_msg.target;
         cur_time <= event_msg.ts;
         cur_type <= event_msg.etype;
         gvt      <= global_time;
         rnd      <= random_in;
      end
   end

   // Next regular event, drawn from the latched random value
   assign new_time   = cur_time + sim_time_t'(MIN_GAP) + sim_time_t'(rnd[5:0]);
   assign new_offset = new_time - cur_time;
   assign new_target = rnd[10:8];

   assign gen_entry = '{zero: '0, target: new_target, offset: new_offset[7:0],
                        etype: cur_type, ts: cur_time};
   assign gen_push  = (state == GEN_EVT) && !discard_cur;
   assign rbk_pop   = ack_wait && !rbk_empty && pair_half;   // Entry done after its re-issue

   always_comb begin
      if (discard_cur)
         primary_msg = gen_cancel ? cancel_msg : NULL_MSG;
      else if (cur_type == CANCEL_EVT)
         primary_msg = NULL_MSG;   // Unmatched cancel only goes into the history
      else
         primary_msg = make_msg(REGULAR_EVT, new_target, new_time);
   end

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (event_valid)
               state_next = stall ? STALL : READ_HIST;
         end
         STALL: begin
            if (!stall)
               state_next = READ_HIST;
         end
         READ_HIST: begin
            if (rd_done)
               state_next = PROC_DELAY;
         end
         PROC_DELAY: begin
            if (delay_cnt == rnd[19:16])
               state_next = GEN_EVT;
         end
         GEN_EVT:    state_next = WRITE_HIST;
         WRITE_HIST: begin
            if (wr_done)
               state_next = SEND_EVT;
         end
         SEND_EVT:   state_next = WAIT;
         WAIT: begin
            if (ack && rbk_empty)
               state_next = IDLE;
         end
         default:    state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state           <= IDLE;
         delay_cnt       <= '0;
         new_event_ready <= 1'b0;
         pair_half       <= 1'b0;
      end else begin
         state     <= state_next;
         delay_cnt <= (state == PROC_DELAY) ? delay_cnt + 1'b1 : '0;
         if (state == SEND_EVT)
            new_event_ready <= 1'b1;
         else if (ack_wait && rbk_empty)
            new_event_ready <= 1'b0;
         if (ready)
            pair_half <= 1'b0;
         else if (ack_wait && !rbk_empty)
            pair_half <= !pair_half;
      end
   end

   always_ff @(posedge clk) begin
      if (state == GEN_EVT)
         new_hist_size <= hist_count + hist_cnt_t'(!discard_cur);   // Kept entries plus new one
      if (state == SEND_EVT)
         out_event_msg <= primary_msg;
      else if (ack_wait && !rbk_empty)
         out_event_msg <= pair_half ? make_msg(REGULAR_EVT, cur_lp, rbk_head.ts)
                                    : cancel_of(rbk_head);
   end

endmodule

/* rtl/evt_ctx_if.sv */
`timescale 1ns/1ps

interface evt_ctx_if import phold_pkg::*; ();

   lp_id_t    cur_lp;     // LP that owns the current event
   sim_time_t cur_time;
   evt_type_e cur_type;
   sim_time_t gvt;        // GVT sampled at acceptance
   logic      in_idle;    // High between events, clears per-event state

   modport source (
      output cur_lp, cur_time, cur_type, gvt, in_idle
   );

   modport sink (
      input cur_lp, cur_time, cur_type, gvt, in_idle
   );

endinterface

/* rtl/fwft_fifo.sv */
`timescale 1ns/1ps

module fwft_fifo #(
   parameter int FIFO_WIDTH = 32,
   parameter int FIFO_DEPTH = 16        // Power of two
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        clr,     // Synchronous flush
   input  logic                        wr_en,
   input  logic [FIFO_WIDTH-1:0]       din,
   input  logic                        rd_en,
   output logic [FIFO_WIDTH-1:0]       dout,
   output logic                        empty,
   output logic [$clog2(FIFO_DEPTH):0] count
);

   localparam int          AW       = $clog2(FIFO_DEPTH);
   localparam logic [AW:0] FULL_CNT = (AW+1)'(FIFO_DEPTH);

   logic [FIFO_WIDTH-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en && (count != FULL_CNT);   // Writes into a full FIFO are lost
   assign do_rd = rd_en && !empty;
   assign empty = (count == '0);

   // Head word is on dout without a read strobe
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst || clr) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

endmodule

/* rtl/hist_access.sv */
`timescale 1ns/1ps

module hist_access import phold_pkg::*; #(
   parameter int FIFO_DEPTH = 16        // History slots per LP
) (
   input  logic        clk,
   input  logic        rst,
   evt_ctx_if.sink     ctx,
   input  core_state_e state,
   input  hist_cnt_t   hist_size,
   input  logic        hist_access_grant,
   input  hist_entry_t buf_head,
   input  logic        buf_empty,
   output logic        hist_rq,
   output logic        hist_wr_en,
   output hist_addr_t  hist_addr,
   output hist_entry_t hist_data_wr,
   output logic        rd_xfer,
   output logic        rd_done,
   output logic        wr_done,
   output logic        buf_pop
);

   hist_cnt_t  slot;
   hist_cnt_t  slot_next;
   hist_addr_t lp_base;
   logic       xfer;
   logic       rd_phase;
   logic       load_wr;
   logic       wr_pending;

   assign xfer    = hist_rq && hist_access_grant;
   assign rd_xfer = xfer && !hist_wr_en;
   assign buf_pop = xfer && hist_wr_en;   // Entry leaves the buffer once it is in memory

   // Last read is the grant of slot hist_size-1, or none at all for an empty history
   assign rd_done = (state == READ_HIST) &&
                    ((hist_size == '0) || (rd_xfer && (slot == hist_size - 1'b1)));
   assign wr_done = (state == WRITE_HIST) && buf_empty && !hist_rq;

   assign rd_phase   = (state == READ_HIST) && (hist_size != '0) && !rd_done;
   assign load_wr    = (state == WRITE_HIST) && !buf_empty && !hist_rq;
   assign wr_pending = hist_rq && hist_wr_en && !hist_access_grant;

   assign lp_base = hist_addr_t'(ctx.cur_lp) * hist_addr_t'(FIFO_DEPTH);

   always_comb begin
      slot_next = slot;
      if (ctx.in_idle || rd_done)
         slot_next = '0;                  // Write-back starts again at slot 0
      else if (xfer)
         slot_next = slot + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         slot       <= '0;
         hist_rq    <= 1'b0;
         hist_wr_en <= 1'b0;
      end else begin
         slot       <= slot_next;
         hist_rq    <= rd_phase || load_wr || wr_pending;
         hist_wr_en <= load_wr || wr_pending;
      end
   end

   // Reads run back to back, each write is reloaded from the new buffer head
   always_ff @(posedge clk) begin
      hist_addr <= lp_base + hist_addr_t'(slot_next);
      if (load_wr)
         hist_data_wr <= buf_head;
   end

endmodule

/* rtl/phold_core.sv */
`timescale 1ns/1ps

module phold_core import phold_pkg::*; #(
   parameter int FIFO_DEPTH = 16,
   parameter int FIFO_WIDTH = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              event_valid,
   input  event_msg_t        event_msg,
   input  sim_time_t         global_time,
   input  logic [NB_RND-1:0] random_in,
   input  logic              stall,
   input  logic              ack,
   input  hist_entry_t       hist_data_rd,
   input  logic              hist_access_grant,
   input  hist_cnt_t         hist_size,
   output logic              ready,
   output logic              active,
   output logic              new_event_ready,
   output event_msg_t        out_event_msg,
   output hist_cnt_t         new_hist_size,
   output logic              hist_rq,
   output logic              hist_wr_en,
   output hist_addr_t        hist_addr,
   output hist_entry_t       hist_data_wr
);

   core_state_e state;
   logic        rd_done, wr_done, rd_xfer;
   logic        buf_pop, buf_empty, buf_wr;
   hist_entry_t buf_head, buf_din;
   logic        keep_push, gen_push;
   hist_entry_t keep_entry, gen_entry;
   logic        discard_cur, gen_cancel;
   event_msg_t  cancel_msg;
   logic        rbk_pop, rbk_empty;
   hist_entry_t rbk_head;
   hist_cnt_t   hist_count;

   evt_ctx_if ctx ();

   // Filtered entries and the new entry never arrive in the same cycle
   assign buf_wr  = keep_push || gen_push;
   assign buf_din = gen_push ? gen_entry : keep_entry;

   event_ctrl u_event_ctrl (
      .clk, .rst, .ctx(ctx.source), .event_valid, .event_msg, .global_time, .random_in,
      .stall, .ack, .ready, .active, .rd_done, .wr_done, .gen_entry, .gen_push,
      .discard_cur, .gen_cancel, .cancel_msg, .rbk_empty, .rbk_head, .rbk_pop,
      .hist_count, .new_hist_size, .new_event_ready, .out_event_msg, .state
   );

   hist_access #(.FIFO_DEPTH(FIFO_DEPTH)) u_hist_access (
      .clk, .rst, .ctx(ctx.sink), .state, .hist_size, .hist_access_grant,
      .buf_head, .buf_empty, .hist_rq, .hist_wr_en, .hist_addr, .hist_data_wr,
      .rd_xfer, .rd_done, .wr_done, .buf_pop
   );

   rollback_filter u_rollback_filter (
      .clk, .rst, .ctx(ctx.sink), .rd_xfer, .hist_data_rd, .keep_push, .keep_entry,
      .discard_cur, .gen_cancel, .cancel_msg, .rbk_pop, .rbk_empty, .rbk_head
   );

   fwft_fifo #(.FIFO_WIDTH(FIFO_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) hist_buffer (
      .clk, .rst, .clr(ctx.in_idle), .wr_en(buf_wr), .din(buf_din), .rd_en(buf_pop),
      .dout(buf_head), .empty(buf_empty), .count(hist_count)
   );

endmodule

/* rtl/phold_pkg.sv */
package phold_pkg;

   localparam int TIME_WID      = 16;
   localparam int NB_LPID       = 3;
   localparam int NB_RND        = 24;
   localparam int NB_HIST_DEPTH = 4;    // 16 history slots per LP
   localparam int NB_HIST_ADDR  = 8;
   localparam int MSG_WID       = 32;
   localparam int HIST_WID      = 32;
   localparam int MIN_GAP       = 10;   // Least gap between current and new event time

   typedef logic [NB_LPID-1:0]      lp_id_t;
   typedef logic [TIME_WID-1:0]     sim_time_t;
   typedef logic [NB_HIST_DEPTH:0]  hist_cnt_t;   // Extra bit so a full LP history fits
   typedef logic [NB_HIST_ADDR-1:0] hist_addr_t;

   typedef enum logic {
      REGULAR_EVT = 1'b0,
      CANCEL_EVT  = 1'b1
   } evt_type_e;

   typedef struct packed {
      logic [MSG_WID-NB_LPID-TIME_WID-2:0] zero;
      evt_type_e                           etype;
      lp_id_t                              target;
      sim_time_t                           ts;
   } event_msg_t;

   typedef struct packed {
      logic [HIST_WID-NB_LPID-TIME_WID-10:0] zero;
      lp_id_t                                target;
      logic [7:0]                            offset;   // Generated event time minus ts
      evt_type_e                             etype;
      sim_time_t                             ts;
   } hist_entry_t;

   typedef enum logic [2:0] {
      IDLE, STALL, READ_HIST, PROC_DELAY, GEN_EVT, WRITE_HIST, SEND_EVT, WAIT
   } core_state_e;

   localparam event_msg_t NULL_MSG = '{zero: '0, etype: CANCEL_EVT, target: '0, ts: '0};

   function automatic event_msg_t make_msg(evt_type_e typ, lp_id_t tgt, sim_time_t t);
      event_msg_t msg;
      msg = '{zero: '0, etype: typ, target: tgt, ts: t};
      return msg;
   endfunction

   // Cancel message that undoes the event a history entry once generated
   function automatic event_msg_t cancel_of(hist_entry_t ent);
      sim_time_t t;
      t = ent.ts + sim_time_t'(ent.offset);
      return make_msg(CANCEL_EVT, ent.target, t);
   endfunction

endpackage

/* rtl/rollback_filter.sv */
`timescale 1ns/1ps

module rollback_filter import phold_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   evt_ctx_if.sink     ctx,
   input  logic        rd_xfer,
   input  hist_entry_t hist_data_rd,
   output logic        keep_push,
   output hist_entry_t keep_entry,
   output logic        discard_cur,   // Also marks that the one allowed match was found
   output logic        gen_cancel,
   output event_msg_t  cancel_msg,
   input  logic        rbk_pop,
   output logic        rbk_empty,
   output hist_entry_t rbk_head
);

   logic expired;
   logic match;
   logic rollback;
   logic rbk_push;

   // Rules are checked in priority order
   always_comb begin
      expired  = 1'b0;
      match    = 1'b0;
      rollback = 1'b0;
      if (hist_data_rd.ts < ctx.gvt) begin
         expired = 1'b1;   // Older than GVT, can never be rolled back
      end else if (hist_data_rd.etype != ctx.cur_type &&
                   hist_data_rd.ts == ctx.cur_time && !discard_cur) begin
         match = 1'b1;     // Event and entry annihilate each other
      end else if (ctx.cur_type == REGULAR_EVT && hist_data_rd.etype == REGULAR_EVT &&
                   hist_data_rd.ts > ctx.cur_time) begin
         rollback = 1'b1;  // Entry was processed too early
      end
   end

   always_ff @(posedge clk) begin
      if (rst || ctx.in_idle) begin
         keep_push   <= 1'b0;
         rbk_push    <= 1'b0;
         discard_cur <= 1'b0;
         gen_cancel  <= 1'b0;
      end else begin
         keep_push <= rd_xfer && !(expired || match || rollback);
         rbk_push  <= rd_xfer && rollback;
         if (rd_xfer && match) begin
            discard_cur <= 1'b1;
            gen_cancel  <= (ctx.cur_type == CANCEL_EVT);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_xfer)
         keep_entry <= hist_data_rd;
      if (rd_xfer && match)
         cancel_msg <= cancel_of(hist_data_rd);   // Undo what the entry sent out
   end

   // Rolled-back entries wait here for their cancel/re-issue pair
   fwft_fifo #(
      .FIFO_WIDTH (HIST_WID),
      .FIFO_DEPTH (2**NB_HIST_DEPTH)
   ) rollback_buffer (
      .clk   (clk),
      .rst   (rst),
      .clr   (ctx.in_idle),
      .wr_en (rbk_push),
      .din   (keep_entry),
      .rd_en (rbk_pop),
      .dout  (rbk_head),
      .empty (rbk_empty),
      .count ()
   );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the phold_core testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
   --top-module phold_core_tb -f src.f -o phold_core_sim

./obj_dir/phold_core_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "Simulation reported failures, see sim.log"
   exit 1
fi
echo "Simulation finished without failures"

/* sim/phold_core_tb.sv */
`timescale 1ns/1ps

module phold_core_tb import phold_pkg::*; ();

   localparam int         NUM_ROWS       = 6;
   localparam int         MAX_ENT        = 4;
   localparam int         MAX_MSG        = 5;
   localparam int         TIMEOUT_CYCLES = NUM_ROWS * 300;
   localparam logic [15:0] LFSR_SEED     = 16'd20994;

   logic              clk, rst;
   logic              event_valid, stall, ack, hist_access_grant;
   event_msg_t        event_msg;
   sim_time_t         global_time;
   logic [NB_RND-1:0] random_in;
   hist_entry_t       hist_data_rd;
   hist_cnt_t         hist_size;
   logic              ready, active, new_event_ready;
   event_msg_t        out_event_msg;
   hist_cnt_t         new_hist_size;
   logic              hist_rq, hist_wr_en;
   hist_addr_t        hist_addr;
   hist_entry_t       hist_data_wr;

   // History memory model with its own preset port used between events
   hist_entry_t hist_mem [256];
   logic        preset_we;
   hist_addr_t  preset_addr;
   hist_entry_t preset_data;
   int          fill_idx;
   logic [15:0] grant_lfsr;
   int          cycles;
   int          msg_errs, entry_errs, size_errs, flag_errs;

   // One row of stimulus and expected results per event
   hist_entry_t       row_hist  [NUM_ROWS][MAX_ENT];
   event_msg_t        row_out   [NUM_ROWS][MAX_MSG];
   hist_entry_t       row_exp   [NUM_ROWS][MAX_ENT];
   event_msg_t        row_msg   [NUM_ROWS];
   sim_time_t         row_gvt   [NUM_ROWS];
   logic [NB_RND-1:0] row_rnd   [NUM_ROWS];
   int                row_hist_n[NUM_ROWS];
   int                row_out_n [NUM_ROWS];
   int                row_exp_n [NUM_ROWS];
   int                row_stall [NUM_ROWS];
   int                row_ack   [NUM_ROWS];

   tb_clkgen u_clkgen (.clk(clk), .rst(rst));

   phold_core #(.FIFO_DEPTH(16), .FIFO_WIDTH(32)) DUT (
      .clk, .rst, .event_valid, .event_msg, .global_time, .random_in, .stall, .ack,
      .hist_data_rd, .hist_access_grant, .hist_size, .ready, .active, .new_event_ready,
      .out_event_msg, .new_hist_size, .hist_rq, .hist_wr_en, .hist_addr, .hist_data_wr
   );

   assign hist_data_rd = hist_mem[hist_addr];   // Read data in the granted cycle

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   function automatic event_msg_t evt_msg(input evt_type_e typ, input int lp, input int ts);
      event_msg_t m;
      m        = '0;
      m.etype  = typ;
      m.target = lp_id_t'(lp);
      m.ts     = sim_time_t'(ts);
      return m;
   endfunction

   function automatic hist_entry_t hist_ent(input int tgt, input int off, input evt_type_e typ,
                                            input int ts);
      hist_entry_t e;
      e        = '0;
      e.target = lp_id_t'(tgt);
      e.offset = 8'(off);
      e.etype  = typ;
      e.ts     = sim_time_t'(ts);
      return e;
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         for (fill_idx = 0; fill_idx < 256; fill_idx++)
            hist_mem[fill_idx] <= hist_entry_t'(32'hC0DE_0000 | 32'(fill_idx * 257));
      end else if (preset_we) begin
         hist_mem[preset_addr] <= preset_data;
      end else if (hist_rq && hist_wr_en && hist_access_grant) begin
         hist_mem[hist_addr] <= hist_data_wr;
      end
   end

   // Random grant with one LFSR step per cycle
   initial begin
      grant_lfsr        = LFSR_SEED;
      hist_access_grant = 1'b0;
      forever begin
         @(negedge clk);
         grant_lfsr        = lfsr_step(grant_lfsr);
         hist_access_grant = grant_lfsr[0];
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check_msg(input string name, input event_msg_t got, input event_msg_t exp);
      if (got !== exp) begin
         msg_errs++;
         $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_entry(input string name, input hist_entry_t got, input hist_entry_t exp);
      if (got !== exp) begin
         entry_errs++;
         $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_size(input string name, input hist_cnt_t got, input hist_cnt_t exp);
      if (got !== exp) begin
         size_errs++;
         $display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errs++;
         $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic set_row(input int r, input evt_type_e typ, input int lp, input int ts,
                          input int gvt, input logic [NB_RND-1:0] rnd, input int hist_n,
                          input int out_n, input int exp_n, input int stall_cyc, input int ack_dly);
      row_msg[r]    = evt_msg(typ, lp, ts);
      row_gvt[r]    = sim_time_t'(gvt);
      row_rnd[r]    = rnd;
      row_hist_n[r] = hist_n;
      row_out_n[r]  = out_n;
      row_exp_n[r]  = exp_n;
      row_stall[r]  = stall_cyc;
      row_ack[r]    = ack_dly;
   endtask

   task automatic load_table();
      // Empty history gives only the new event
      set_row(0, REGULAR_EVT, 2, 100, 50, 24'h03_0507, 0, 1, 1, 0, 0);
      row_hist[0] = '{'0, '0, '0, '0};
      row_out[0]  = '{evt_msg(REGULAR_EVT, 5, 117), '0, '0, '0, '0};
      row_exp[0]  = '{hist_ent(5, 17, REGULAR_EVT, 100), '0, '0, '0};
      // Entries below GVT drop out
      set_row(1, REGULAR_EVT, 1, 80, 40, 24'h0A_0315, 4, 1, 3, 0, 2);
      row_hist[1] = '{hist_ent(3, 12, REGULAR_EVT, 20), hist_ent(4, 15, REGULAR_EVT, 60),
                      hist_ent(2, 11, REGULAR_EVT, 30), hist_ent(0, 20, REGULAR_EVT, 70)};
      row_out[1]  = '{evt_msg(REGULAR_EVT, 3, 111), '0, '0, '0, '0};
      row_exp[1]  = '{hist_ent(4, 15, REGULAR_EVT, 60), hist_ent(0, 20, REGULAR_EVT, 70),
                      hist_ent(3, 31, REGULAR_EVT, 80), '0};
      // Straggler rolls back two later entries
      set_row(2, REGULAR_EVT, 4, 100, 30, 24'h01_0402, 4, 5, 3, 0, 1);
      row_hist[2] = '{hist_ent(1, 14, REGULAR_EVT, 50), hist_ent(6, 25, REGULAR_EVT, 130),
                      hist_ent(2, 16, REGULAR_EVT, 90), hist_ent(5, 22, REGULAR_EVT, 150)};
      row_out[2]  = '{evt_msg(REGULAR_EVT, 4, 112), evt_msg(CANCEL_EVT, 6, 155),
                      evt_msg(REGULAR_EVT, 4, 130), evt_msg(CANCEL_EVT, 5, 172),
                      evt_msg(REGULAR_EVT, 4, 150)};
      row_exp[2]  = '{hist_ent(1, 14, REGULAR_EVT, 50), hist_ent(2, 16, REGULAR_EVT, 90),
                      hist_ent(4, 12, REGULAR_EVT, 100), '0};
      // Cancel annihilates its regular entry
      set_row(3, CANCEL_EVT, 3, 75, 10, 24'h05_0000, 3, 1, 2, 2, 0);
      row_hist[3] = '{hist_ent(2, 18, REGULAR_EVT, 40), hist_ent(7, 13, REGULAR_EVT, 75),
                      hist_ent(1, 19, REGULAR_EVT, 90), '0};
      row_out[3]  = '{evt_msg(CANCEL_EVT, 7, 88), '0, '0, '0, '0};
      row_exp[3]  = '{hist_ent(2, 18, REGULAR_EVT, 40), hist_ent(1, 19, REGULAR_EVT, 90), '0, '0};
      // Unmatched cancel is stored
      set_row(4, CANCEL_EVT, 6, 210, 100, 24'h00_0601, 1, 1, 2, 0, 3);
      row_hist[4] = '{hist_ent(0, 11, REGULAR_EVT, 200), '0, '0, '0};
      row_out[4]  = '{evt_msg(CANCEL_EVT, 0, 0), '0, '0, '0, '0};
      row_exp[4]  = '{hist_ent(0, 11, REGULAR_EVT, 200), hist_ent(6, 11, CANCEL_EVT, 210), '0, '0};
      // Stall at acceptance with a slow ack
      set_row(5, REGULAR_EVT, 0, 250, 200, 24'h02_0109, 1, 3, 1, 5, 4);
      row_hist[5] = '{hist_ent(3, 10, REGULAR_EVT, 300), '0, '0, '0};
      row_out[5]  = '{evt_msg(REGULAR_EVT, 1, 269), evt_msg(CANCEL_EVT, 3, 310),
                      evt_msg(REGULAR_EVT, 0, 300), '0, '0};
      row_exp[5]  = '{hist_ent(1, 19, REGULAR_EVT, 250), '0, '0, '0};
   endtask

   task automatic run_row(input int r);
      int base;
      int k;
      base = int'(row_msg[r].target) * 16;
      for (k = 0; k < row_hist_n[r]; k++) begin
         preset_we   = 1'b1;
         preset_addr = hist_addr_t'(base + k);
         preset_data = row_hist[r][k];
         @(negedge clk);
      end
      preset_we   = 1'b0;
      event_valid = 1'b1;
      event_msg   = row_msg[r];
      global_time = row_gvt[r];
      random_in   = row_rnd[r];
      hist_size   = hist_cnt_t'(row_hist_n[r]);
      stall       = (row_stall[r] > 0);
      @(negedge clk);
      event_valid = 1'b0;
      for (k = 1; k < row_stall[r]; k++) begin
         check_flag("ready", ready, 1'b0);
         check_flag("hist_rq", hist_rq, 1'b0);   // Nothing moves while stalled
         @(negedge clk);
      end
      stall = 1'b0;
      for (k = 0; k < row_out_n[r]; k++) begin
         while (!new_event_ready) begin
            check_flag("ready", ready, 1'b0);
            check_flag("active", active, 1'b1);
            @(negedge clk);
         end
         check_msg("out_event_msg", out_event_msg, row_out[r][k]);
         check_size("new_hist_size", new_hist_size, hist_cnt_t'(row_exp_n[r]));
         repeat (row_ack[r]) begin
            @(negedge clk);
            check_msg("out_event_msg", out_event_msg, row_out[r][k]);
            check_flag("new_event_ready", new_event_ready, 1'b1);
            check_flag("ready", ready, 1'b0);
         end
         ack = 1'b1;
         @(negedge clk);
         ack = 1'b0;
      end
      // One cycle after the last ack the core is back in IDLE
      check_flag("new_event_ready", new_event_ready, 1'b0);
      check_flag("ready", ready, 1'b1);
      check_flag("active", active, 1'b0);
      for (k = 0; k < row_exp_n[r]; k++)
         check_entry($sformatf("hist_mem[%0d]", base + k), hist_mem[base + k], row_exp[r][k]);
   endtask

   initial begin
      int r;
      event_valid = 1'b0;
      event_msg   = '0;
      global_time = '0;
      random_in   = '0;
      stall       = 1'b0;
      ack         = 1'b0;
      hist_size   = '0;
      preset_we   = 1'b0;
      preset_addr = '0;
      preset_data = '0;
      msg_errs    = 0;
      entry_errs  = 0;
      size_errs   = 0;
      flag_errs   = 0;
      load_table();
      @(negedge clk);
      while (rst)
         @(negedge clk);
      check_flag("new_event_ready", new_event_ready, 1'b0);
      check_flag("hist_rq", hist_rq, 1'b0);
      check_flag("hist_wr_en", hist_wr_en, 1'b0);
      check_flag("active", active, 1'b0);
      check_flag("ready", ready, 1'b1);
      for (r = 0; r < NUM_ROWS; r++)
         run_row(r);
      $display("Errors: %0d message, %0d history, %0d size, %0d flag",
               msg_errs, entry_errs, size_errs, flag_errs);
      if (msg_errs + entry_errs + size_errs + flag_errs == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* sim/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int HALF_PERIOD = 10,   // 20 ns clock
   parameter int RST_CYCLES  = 16
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;   // Released away from the active edge
   end

endmodule

/* src.f */
rtl/phold_pkg.sv
rtl/evt_ctx_if.sv
rtl/fwft_fifo.sv
rtl/hist_access.sv
rtl/rollback_filter.sv
rtl/event_ctrl.sv
rtl/phold_core.sv
sim/tb_clkgen.sv
sim/phold_core_tb.sv
